// ==== rtl/router_config.svh ====
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// Flit field widths.
`define ROUTER_DATA_W 32
`define ROUTER_LEN_W 12
`define ROUTER_ID_W 3

// Flits held per input buffer.
`define ROUTER_FIFO_DEPTH 8

// Local, North, East, West, South.
`define ROUTER_PORTS 5

`endif

// ==== rtl/flitPkg.sv ====
`include "router_config.svh"

package flitPkg;

  // Flit-id field of every flit.
  typedef enum logic [`ROUTER_ID_W-1:0] {
    kindIdle = 0,
    kindHead = 1,
    kindBody = 2,
    kindTail = 3
  } flitKindE;

  typedef logic [`ROUTER_LEN_W-1:0] flitLenT;
  typedef logic [`ROUTER_DATA_W-1:0] flitDataT;

  // One flit as stored in the buffers and sent on the output.
  typedef struct packed {
    flitKindE kind;
    flitLenT length;  // Packet length in flits, head included.
    flitDataT payload;
  } flitT;

endpackage

// ==== rtl/arbPkg.sv ====
package arbPkg;

  // Input port index, also the rotation order.
  typedef enum logic [2:0] {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portIdxE;

  // One-hot arbiter state, bit n+1 grants port n.
  typedef enum logic [5:0] {
    stIdle = 6'b000001,
    stL = 6'b000010,
    stN = 6'b000100,
    stE = 6'b001000,
    stW = 6'b010000,
    stS = 6'b100000
  } arbStateE;

endpackage

// ==== rtl/flitFifo.sv ====
`include "router_config.svh"

module flitFifo (
  input  logic           clk,
  input  logic           rst,
  input  flitPkg::flitT  wrFlit,
  input  logic           write,
  input  logic           pop,
  output flitPkg::flitT  headFlit,
  output logic           empty,
  output logic           full
);

  import flitPkg::*;

  localparam int depth = `ROUTER_FIFO_DEPTH;
  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

  flitT mem [depth];
  logic [ptrW-1:0] rdPtr;
  logic [ptrW-1:0] wrPtr;
  logic [ptrW:0] count;
  logic doWrite;
  logic doPop;

  assign doWrite = write && !full;  // Writes into a full buffer are lost.
  assign doPop = pop && !empty;

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      mem[wrPtr] <= wrFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
      begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doWrite, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign headFlit = mem[rdPtr];  // Oldest entry.
  assign empty = (count == '0);
  assign full = (count == (ptrW + 1)'(depth));

  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("flitFifo: pop while empty");

  writeNotFull: assert property (@(posedge clk) disable iff (rst) write |-> !full)
    else $error("flitFifo: write while full, flit dropped");

endmodule

// ==== rtl/packetTimer.sv ====
`include "router_config.svh"

module packetTimer (
  input  logic           clk,
  input  logic           rst,
  input  flitPkg::flitT  headFlit,
  input  logic           runTimer,
  output logic           timesUp
);

  import flitPkg::*;

  flitLenT limit;
  flitLenT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // A fresh head at the buffer front sets the packet length.
      if (headFlit.kind == kindHead)
      begin
        limit <= headFlit.length;
      end
      if (!runTimer)
      begin
        count <= '0;  // Grant paused or moved on.
      end
      else
      begin
        count <= count + 1'b1;
      end
    end
  end

  // Reached after exactly length granted transfers.
  assign timesUp = (count == limit);

  headLenNonZero: assert property (@(posedge clk) disable iff (rst)
    headFlit.kind == kindHead |-> headFlit.length != '0)
    else $error("packetTimer: head flit with zero length");

endmodule

// ==== rtl/outputArbiter.sv ====
`include "router_config.svh"

module outputArbiter (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [`ROUTER_PORTS-1:0]                req,
  input  flitPkg::flitT [`ROUTER_PORTS-1:0]       headFlits,
  output logic [`ROUTER_PORTS-1:0]                pop,
  output arbPkg::arbStateE                        grant
);

  import arbPkg::*;

  arbStateE state;
  arbStateE nextState;
  portIdxE searchStart;
  logic [`ROUTER_PORTS-1:0] timesUp;

  // First requester at or after start, wrapping around the ports.
  function automatic arbStateE pickFrom(
    input logic [`ROUTER_PORTS-1:0] r,
    input portIdxE start
  );
    int idx;
    arbStateE pick;
    pick = stIdle;
    for (int k = `ROUTER_PORTS - 1; k >= 0; k--)
    begin
      idx = int'(start) + k;
      if (idx >= `ROUTER_PORTS)
      begin
        idx = idx - `ROUTER_PORTS;
      end
      if (r[idx])
      begin
        pick = arbStateE'(6'b000010 << idx);  // Lowest k wins.
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : genTimer
    packetTimer uTimer (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlits[i]),
      .runTimer (pop[i]),
      .timesUp  (timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // Granted port moves while it still requests and its packet is not done.
  assign pop = state[`ROUTER_PORTS:1] & req & ~timesUp;

  // Search begins just after the current owner, so the owner comes last.
  always_comb
  begin
    case (state)
      stL:     searchStart = portN;
      stN:     searchStart = portE;
      stE:     searchStart = portW;
      stW:     searchStart = portS;
      stS:     searchStart = portL;
      default: searchStart = portL;  // Idle scans from Local.
    endcase
  end

  always_comb
  begin
    if (state != stIdle && (|pop))
    begin
      nextState = state;
    end
    else
    begin
      nextState = pickFrom(req, searchStart);
    end
  end

  assign grant = state;

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("outputArbiter: state not one-hot");

  popOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("outputArbiter: more than one pop");

endmodule

// ==== rtl/outputPortUnit.sv ====
`include "router_config.svh"

module outputPortUnit (
  input  logic                                clk,
  input  logic                                rst,
  input  flitPkg::flitT [`ROUTER_PORTS-1:0]   inFlit,
  input  logic [`ROUTER_PORTS-1:0]            inWrite,
  output logic [`ROUTER_PORTS-1:0]            inFull,
  output flitPkg::flitT                       outFlit,
  output logic                                outValid,
  output arbPkg::arbStateE                    grant
);

  import flitPkg::*;

  flitT [`ROUTER_PORTS-1:0] headFlit;
  logic [`ROUTER_PORTS-1:0] empty;
  logic [`ROUTER_PORTS-1:0] pop;
  flitT selFlit;

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : genBuf
    flitFifo uFifo (
      .clk      (clk),
      .rst      (rst),
      .wrFlit   (inFlit[i]),
      .write    (inWrite[i]),
      .pop      (pop[i]),
      .headFlit (headFlit[i]),
      .empty    (empty[i]),
      .full     (inFull[i])
    );
  end

  outputArbiter uArb (
    .clk       (clk),
    .rst       (rst),
    .req       (~empty),
    .headFlits (headFlit),
    .pop       (pop),
    .grant     (grant)
  );

  // Crossbar column: pop is one-hot, so this is a plain select.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      if (pop[i])
      begin
        selFlit = headFlit[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= selFlit;  // Holds last flit when idle.
    end
  end

endmodule

// ==== dv/tbOutputPort.sv ====
`include "router_config.svh"

module tbOutputPort;

  timeunit 1ns;
  timeprecision 1ps;

  import flitPkg::*;
  import arbPkg::*;

  localparam int numPorts = `ROUTER_PORTS;
  localparam int depth = `ROUTER_FIFO_DEPTH;
  localparam int numTests = 5;

  logic clk;
  logic rst;
  flitT [numPorts-1:0] inFlit;
  logic [numPorts-1:0] inWrite;
  logic [numPorts-1:0] inFull;
  flitT outFlit;
  logic outValid;
  arbStateE grant;

  flitT pending [numPorts][$];  // Flits not yet driven.
  flitT modelQ [numPorts][$];  // Flits the model holds per buffer.
  arbStateE expGrant;
  int expLeft;  // Transfers left in the granted packet.
  flitT expFlit;
  logic expValid;
  logic [numPorts-1:0] expFull;

  int testId = 0;
  int errCount = 0;
  int passCount = 0;
  int failCount = 0;
  int cycles = 0;
  int flitsWritten = 0;

  outputPortUnit DUT (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inWrite  (inWrite),
    .inFull   (inFull),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grant    (grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > 40 * numTests + 8 * flitsWritten)
    begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // One flit per port per cycle, taken from the pending queues.
  always @(posedge clk)
  begin
    #2;
    for (int p = 0; p < numPorts; p++)
    begin
      if (pending[p].size() > 0)
      begin
        inFlit[p] = pending[p].pop_front();
        inWrite[p] = 1'b1;
      end
      else
      begin
        inWrite[p] = 1'b0;
      end
    end
  end

  function automatic int portOf(arbStateE s);
    case (s)
      stL:     return 0;
      stN:     return 1;
      stE:     return 2;
      stW:     return 3;
      stS:     return 4;
      default: return -1;
    endcase
  endfunction

  function automatic arbStateE stateOf(int p);
    case (p)
      0:       return stL;
      1:       return stN;
      2:       return stE;
      3:       return stW;
      default: return stS;
    endcase
  endfunction

  // Reference model of buffers, grant rotation and output register.
  always @(posedge clk)
  begin
    int cur;
    int start;
    int idx;
    logic doPop;
    logic found;
    arbStateE nextGrant;
    if (rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        modelQ[p].delete();
      end
      expGrant = stIdle;
      expLeft = 0;
      expFlit = '0;
      expValid = 1'b0;
    end
    else
    begin
      cur = portOf(expGrant);
      doPop = (cur >= 0) && (modelQ[cur].size() > 0) && (expLeft > 0);
      nextGrant = stIdle;
      if (doPop)
      begin
        nextGrant = expGrant;
        expLeft--;
      end
      else
      begin
        start = (cur >= 0) ? (cur + 1) % numPorts : 0;  // Owner is searched last.
        found = 1'b0;
        for (int k = 0; k < numPorts; k++)
        begin
          idx = (start + k) % numPorts;
          if (!found && modelQ[idx].size() > 0)
          begin
            found = 1'b1;
            nextGrant = stateOf(idx);
            expLeft = modelQ[idx][0].length;
          end
        end
        if (!found)
        begin
          expLeft = 0;
        end
      end
      // Full level is the one before this edge's pop.
      for (int p = 0; p < numPorts; p++)
      begin
        if (inWrite[p] && modelQ[p].size() < depth)
        begin
          modelQ[p].push_back(inFlit[p]);
        end
      end
      if (doPop)
      begin
        expFlit = modelQ[cur].pop_front();
      end
      expValid = doPop;
      expGrant = nextGrant;
    end
    for (int p = 0; p < numPorts; p++)
    begin
      expFull[p] = (modelQ[p].size() == depth);
    end
  end

  grantMatch: assert property (@(posedge clk) disable iff (rst) grant == expGrant)
    else
    begin
      errCount++;
      $display("mismatch grant: got %h expected %h", $sampled(grant), $sampled(expGrant));
    end

  validMatch: assert property (@(posedge clk) disable iff (rst) outValid == expValid)
    else
    begin
      errCount++;
      $display("mismatch outValid: got %h expected %h", $sampled(outValid),
        $sampled(expValid));
    end

  flitMatch: assert property (@(posedge clk) disable iff (rst) outValid |-> outFlit == expFlit)
    else
    begin
      errCount++;
      $display("mismatch outFlit: got %h expected %h", $sampled(outFlit), $sampled(expFlit));
    end

  fullMatch: assert property (@(posedge clk) disable iff (rst) inFull == expFull)
    else
    begin
      errCount++;
      $display("mismatch inFull: got %h expected %h", $sampled(inFull), $sampled(expFull));
    end

  resetState: assert property (@(posedge clk)
    $fell(rst) |-> grant == stIdle && !outValid && inFull == '0)
    else
    begin
      errCount++;
      $display("outputs were not idle when reset was released");
    end

  // Written at edge t, visible after t+2, so sampled at t+3.
  firstFlitLatency: assert property (@(posedge clk) disable iff (rst)
    (testId == 2) && $rose(inWrite[1]) |-> ##3 (outValid && outFlit.kind == kindHead))
    else
    begin
      errCount++;
      $display("North head flit did not appear two cycles after its first write");
    end

  task automatic queuePacket(input int port, input int len);
    flitT f;
    for (int i = 0; i < len; i++)
    begin
      f.kind = (i == 0) ? kindHead : ((i == len - 1) ? kindTail : kindBody);
      f.length = (i == 0) ? flitLenT'(len) : '0;
      f.payload = $urandom();
      pending[port].push_back(f);
    end
    flitsWritten += len;
  endtask

  task automatic waitDrain();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = outValid || (grant != stIdle) || (|inWrite);
      for (int p = 0; p < numPorts; p++)
      begin
        if (pending[p].size() > 0 || modelQ[p].size() > 0)
        begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic waitGrant(input arbStateE s);
    @(negedge clk);
    while (grant != s)
    begin
      @(negedge clk);
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    if (errCount == errBefore)
    begin
      passCount++;
      $display("test %0d %s: passed", testId, name);
    end
    else
    begin
      failCount++;
      $display("test %0d %s: failed with %0d errors", testId, name, errCount - errBefore);
    end
  endtask

  initial
  begin
    int errBefore;
    void'($urandom(32'h2c6c27ad));
    rst = 1'b1;
    inWrite = '0;
    inFlit = '0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    testId = 1;
    errBefore = errCount;
    repeat (3) @(negedge clk);
    idleCheck: assert (grant == stIdle && !outValid && inFull == '0)
      else
      begin
        errCount++;
        $display("mismatch after reset: grant %h outValid %h inFull %h", grant, outValid,
          inFull);
      end
    finishTest("reset state", errBefore);

    testId = 2;
    errBefore = errCount;
    queuePacket(1, $urandom_range(1, 6));
    waitDrain();
    finishTest("single North packet", errBefore);

    testId = 3;
    errBefore = errCount;
    for (int p = 0; p < numPorts; p++)
    begin
      queuePacket(p, $urandom_range(1, 6));
    end
    waitDrain();
    finishTest("five ports at once", errBefore);

    testId = 4;
    errBefore = errCount;
    queuePacket(2, 6);
    waitGrant(stE);
    queuePacket(0, $urandom_range(1, 6));
    queuePacket(4, $urandom_range(1, 6));
    while (grant == stE)
    begin
      @(negedge clk);
    end
    rotateCheck: assert (grant == stS)
      else
      begin
        errCount++;
        $display("mismatch grant after East: got %h expected %h", grant, stS);
      end
    waitDrain();
    finishTest("rotation after East", errBefore);

    testId = 5;
    errBefore = errCount;
    queuePacket(0, 20);
    waitGrant(stL);
    queuePacket(3, depth);
    while (pending[3].size() > 0)
    begin
      @(negedge clk);
    end
    @(negedge clk);  // Last West flit is written at this edge.
    westFull: assert (inFull[3])
      else
      begin
        errCount++;
        $display("mismatch inFull West: got %h expected %h", inFull[3], 1'b1);
      end
    waitDrain();
    finishTest("West buffer full", errBefore);

    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0 && errCount == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/flitPkg.sv
rtl/arbPkg.sv
rtl/flitFifo.sv
rtl/packetTimer.sv
rtl/outputArbiter.sv
rtl/outputPortUnit.sv
dv/tbOutputPort.sv

// ==== Bender.yml ====
package:
  name: output_port_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/flitPkg.sv
      - rtl/arbPkg.sv
      - rtl/flitFifo.sv
      - rtl/packetTimer.sv
      - rtl/outputArbiter.sv
      - rtl/outputPortUnit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tbOutputPort.sv
